/* src.f */
+incdir+tb
design/rv_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/reg_file.sv
design/execute_stage.sv
design/mem_stage.sv
design/rv_core.sv
tb/rv_core_checker.sv
tb/tb_rv_core.sv

/* tb/tb_rv_encode.svh */
`ifndef TB_RV_ENCODE_SVH
`define TB_RV_ENCODE_SVH

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [6:0] op);
  return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [6:0] op);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
endfunction

// offset in bytes, bit 0 is dropped
function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [6:0] op);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] op);
  return {imm, rd, op};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd,
                                       input logic [6:0] op);
  return {off[20], off[10:1], off[11], off[19:12], rd, op};
endfunction

// reference alu, alt is instruction bit 30
function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
  logic [4:0] sh;
  sh = b[4:0];
  case (f3)
    3'd0:    return alt ? a - b : a + b;
    3'd1:    return a << sh;
    // signed compare by flipping the sign bits
    3'd2:    return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
    3'd3:    return (a < b) ? 32'd1 : 32'd0;
    3'd4:    return a ^ b;
    3'd5:    return alt ? ((a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh))) : (a >> sh);
    3'd6:    return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
  logic lt;
  lt = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
  case (f3)
    3'd0:    return a == b;
    3'd1:    return a != b;
    3'd4:    return lt;
    3'd5:    return !lt;
    3'd6:    return a < b;
    3'd7:    return a >= b;
    default: return 1'b0;
  endcase
endfunction

`endif

/* tb/tb_rv_core.sv */
`timescale 1ns/1ns

module tb_rv_core;

  import rv_pkg::*;

  `include "tb_rv_encode.svh"

  logic        clk;
  logic        arst_n;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic        io_valid;
  logic [31:0] io_data;
  logic        halted;

  logic [31:0] rom [256];
  int          prog_len;
  logic [31:0] got_q[$];
  logic [31:0] exp_q[$];
  integer      seed;
  int          checks;
  int          errors;
  int          errors_at_start;
  int          tests;
  int          total;

  rv_core dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .io_valid  (io_valid),
    .io_data   (io_data),
    .halted    (halted)
  );

  // combinational rom
  assign imem_data = rom[imem_addr[9:2]];

  always #10 clk = ~clk;

  always @(negedge clk) begin
    if (arst_n === 1'b1 && io_valid === 1'b1) begin
      got_q.push_back(io_data);
    end
  end

  task automatic put_insn(input logic [31:0] w);
    rom[prog_len] = w;
    prog_len++;
  endtask

  task automatic put_ebreak();
    put_insn(i_type(12'h001, 5'd0, 3'd0, 5'd0, OPC_SYSTEM));
  endtask

  task automatic emit_reg(input logic [4:0] r);
    put_insn(s_type(12'd0, r, 5'd31, 3'b010, OPC_STORE));
  endtask

  // lui/addi pair, upper part rounded for the signed low half
  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800;
    put_insn(u_type(hi[31:12], rd, OPC_LUI));
    put_insn(i_type(v[11:0], rd, 3'b000, rd, OPC_OP_IMM));
  endtask

  task automatic clear_program();
    for (int i = 0; i < 256; i++) begin
      rom[i] = i_type(12'h001, 5'd0, 3'd0, 5'd0, OPC_SYSTEM);
    end
    prog_len = 0;
    exp_q.delete();
    errors_at_start = errors;
    // x31 holds the output port address
    put_insn(u_type(20'h80000, 5'd31, OPC_LUI));
  endtask

  task automatic run_program(input string name);
    int cycles;
    put_ebreak();
    @(posedge clk);
    #2 arst_n = 1'b0;
    got_q.delete();
    repeat (16) @(posedge clk);
    #2 arst_n = 1'b1;
    cycles = 0;
    while (halted !== 1'b1 && cycles < 5000) begin
      @(negedge clk);
      cycles++;
    end
    checks++;
    assert (halted === 1'b1) else begin
      $display("%s: core did not halt within %0d cycles", name, cycles);
      errors++;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expv,
                             input logic [31:0] actv);
    checks++;
    assert (actv === expv) else begin
      $display("[ERROR] %s: expected %08h, actual %08h", name, expv, actv);
      errors++;
    end
  endtask

  task automatic check_outputs(input string name);
    checks++;
    assert (got_q.size() == exp_q.size()) else begin
      $display("%s: output port gave %0d words where %0d were expected",
               name, got_q.size(), exp_q.size());
      errors++;
    end
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
      check_value(name, exp_q[i], got_q[i]);
    end
    tests++;
    $display("test %s finished: %0d words, %0d errors",
             name, got_q.size(), errors - errors_at_start);
  endtask

  task automatic test_alu_ops();
    logic [31:0] a;
    logic [31:0] b;
    logic [11:0] imm;
    logic [6:0]  f7;
    clear_program();
    for (int round = 0; round < 2; round++) begin
      a = $random(seed);
      b = $random(seed);
      load_const(5'd1, a);
      load_const(5'd2, b);
      for (int f3 = 0; f3 < 8; f3++) begin
        for (int alt = 0; alt < 2; alt++) begin
          f7 = (alt == 1) ? 7'h20 : 7'h00;
          if (alt == 0 || f3 == 0 || f3 == 5) begin
            put_insn(r_type(f7, 5'd2, 5'd1, f3[2:0], 5'd3, OPC_OP));
            emit_reg(5'd3);
            exp_q.push_back(alu_model(f3[2:0], alt[0], a, b));
          end
          // no subi, shifts carry the alt bit in the immediate
          if (alt == 0 || f3 == 5) begin
            imm = $random(seed);
            if (f3 == 1 || f3 == 5) begin
              imm = {f7, imm[4:0]};
            end
            put_insn(i_type(imm, 5'd1, f3[2:0], 5'd4, OPC_OP_IMM));
            emit_reg(5'd4);
            exp_q.push_back(alu_model(f3[2:0], alt[0], a, {{20{imm[11]}}, imm}));
          end
        end
      end
    end
    run_program("alu_ops");
    check_outputs("alu_ops");
  endtask

  task automatic test_branches();
    logic [2:0]  conds [6];
    logic [31:0] pa;
    logic [31:0] pb;
    logic [11:0] fall_mark;
    logic [11:0] taken_mark;
    int          n;
    conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    n = 10;
    clear_program();
    // sum 1..n into x1
    put_insn(i_type(12'd0, 5'd0, 3'd0, 5'd1, OPC_OP_IMM));
    put_insn(i_type(12'd0, 5'd0, 3'd0, 5'd2, OPC_OP_IMM));
    put_insn(i_type(n[11:0], 5'd0, 3'd0, 5'd3, OPC_OP_IMM));
    put_insn(i_type(12'd1, 5'd2, 3'd0, 5'd2, OPC_OP_IMM));
    put_insn(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd1, OPC_OP));
    put_insn(b_type(-13'sd8, 5'd3, 5'd2, 3'b001, OPC_BRANCH));
    emit_reg(5'd1);
    exp_q.push_back(n * (n + 1) / 2);
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 2; p++) begin
        if (conds[c] < 3'd2) begin
          pa = 32'd7;
          pb = (p == 0) ? 32'd7 : 32'd3;
        end else begin
          pa = (p == 0) ? -32'sd5 : 32'd3;
          pb = (p == 0) ? 32'd3 : -32'sd5;
        end
        fall_mark  = 12'h200 + 12'(c * 2 + p);
        taken_mark = 12'h400 + 12'(c * 2 + p);
        put_insn(i_type(pa[11:0], 5'd0, 3'd0, 5'd4, OPC_OP_IMM));
        put_insn(i_type(pb[11:0], 5'd0, 3'd0, 5'd5, OPC_OP_IMM));
        put_insn(b_type(13'd16, 5'd5, 5'd4, conds[c], OPC_BRANCH));
        put_insn(i_type(fall_mark, 5'd0, 3'd0, 5'd6, OPC_OP_IMM));
        emit_reg(5'd6);
        put_insn(j_type(21'd12, 5'd0, OPC_JAL));
        put_insn(i_type(taken_mark, 5'd0, 3'd0, 5'd6, OPC_OP_IMM));
        emit_reg(5'd6);
        exp_q.push_back(branch_model(conds[c], pa, pb) ? {20'd0, taken_mark}
                                                        : {20'd0, fall_mark});
      end
    end
    run_program("branches");
    check_outputs("branches");
  endtask

  task automatic test_memory();
    logic [31:0] addrs [5];
    logic [31:0] words [5];
    int          order [5];
    addrs = '{32'h000, 32'h040, 32'h3fc, 32'h104, 32'h2a8};
    order = '{3, 0, 4, 2, 1};
    clear_program();
    // store through base minus 8 with offset 8
    for (int i = 0; i < 5; i++) begin
      words[i] = $random(seed);
      load_const(5'd1, words[i]);
      load_const(5'd2, addrs[i] - 32'd8);
      put_insn(s_type(12'd8, 5'd1, 5'd2, 3'b010, OPC_STORE));
    end
    for (int i = 0; i < 5; i++) begin
      load_const(5'd2, addrs[order[i]]);
      put_insn(i_type(12'd0, 5'd2, 3'b010, 5'd3, OPC_LOAD));
      emit_reg(5'd3);
      exp_q.push_back(words[order[i]]);
    end
    run_program("memory");
    check_outputs("memory");
  endtask

  task automatic test_jumps();
    logic [31:0] base;
    int          p;
    clear_program();
    p = prog_len;
    put_insn(j_type(21'd12, 5'd5, OPC_JAL));
    put_insn(i_type(12'h7ad, 5'd0, 3'd0, 5'd6, OPC_OP_IMM));
    emit_reg(5'd6);
    emit_reg(5'd5);
    exp_q.push_back(p * 4 + 4);
    // rs1 plus imm lands one byte past the target
    p = prog_len + 1;
    base = (p + 3) * 4 - 4;
    put_insn(i_type(base[11:0], 5'd0, 3'd0, 5'd7, OPC_OP_IMM));
    put_insn(i_type(12'd5, 5'd7, 3'd0, 5'd8, OPC_JALR));
    put_insn(i_type(12'h7ad, 5'd0, 3'd0, 5'd6, OPC_OP_IMM));
    emit_reg(5'd6);
    emit_reg(5'd8);
    exp_q.push_back(p * 4 + 4);
    run_program("jumps");
    check_outputs("jumps");
  endtask

  task automatic test_upper_imm();
    logic [19:0] u;
    int          p;
    clear_program();
    put_insn(i_type(12'h123, 5'd0, 3'd0, 5'd0, OPC_OP_IMM));
    emit_reg(5'd0);
    exp_q.push_back(32'd0);
    u = $random(seed);
    put_insn(u_type(u, 5'd9, OPC_LUI));
    emit_reg(5'd9);
    exp_q.push_back({u, 12'h000});
    u = $random(seed);
    p = prog_len;
    put_insn(u_type(u, 5'd10, OPC_AUIPC));
    emit_reg(5'd10);
    exp_q.push_back(p * 4 + {u, 12'h000});
    run_program("upper_imm");
    check_outputs("upper_imm");
  endtask

  task automatic test_halt();
    int e;
    clear_program();
    put_insn(i_type(12'h0a5, 5'd0, 3'd0, 5'd1, OPC_OP_IMM));
    emit_reg(5'd1);
    exp_q.push_back(32'h0a5);
    e = prog_len;
    put_ebreak();
    // never reached
    put_insn(i_type(12'h05a, 5'd0, 3'd0, 5'd1, OPC_OP_IMM));
    emit_reg(5'd1);
    run_program("halt");
    for (int i = 0; i < 50; i++) begin
      @(negedge clk);
      checks++;
      assert (halted === 1'b1) else begin
        $display("halt: halted dropped %0d cycles after the EBREAK", i);
        errors++;
      end
      check_value("halt", e * 4, imem_addr);
    end
    check_outputs("halt");
  endtask

  initial begin
    clk    = 1'b0;
    arst_n = 1'b0;
    seed   = 79277;
    checks = 0;
    errors = 0;
    tests  = 0;
    test_alu_ops();
    test_branches();
    test_memory();
    test_jumps();
    test_upper_imm();
    test_halt();
    total = errors + dut.u_checker.fail_count;
    $display("%0d tests, %0d checks, %0d check errors, %0d assertion failures",
             tests, checks, errors, dut.u_checker.fail_count);
    if (total == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* tb/rv_core_checker.sv */
`timescale 1ns/1ns

module rv_core_checker (
  input logic                    clk,
  input logic                    arst_n,
  input logic                    io_valid,
  input logic [rv_pkg::XLEN-1:0] imem_addr,
  input logic                    halted
);

  int unsigned fail_count = 0;

  // output strobe is a single-cycle pulse
  io_single_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    io_valid |=> !io_valid)
    else begin
      $error("io_valid high in two consecutive cycles");
      fail_count++;
    end

  fetch_aligned: assert property (@(posedge clk) disable iff (!arst_n)
    imem_addr[1:0] == 2'b00)
    else begin
      $error("imem_addr not word aligned");
      fail_count++;
    end

  // halted core is frozen until reset
  halt_frozen: assert property (@(posedge clk) disable iff (!arst_n)
    halted |=> halted && $stable(imem_addr))
    else begin
      $error("halted dropped or imem_addr moved while halted");
      fail_count++;
    end

endmodule

bind rv_core rv_core_checker u_checker (
  .clk       (clk),
  .arst_n    (arst_n),
  .io_valid  (io_valid),
  .imem_addr (imem_addr),
  .halted    (halted)
);

/* design/rv_core.sv */
`timescale 1ns/1ns

module rv_core (
  input  logic                    clk,
  input  logic                    arst_n,
  output logic [rv_pkg::XLEN-1:0] imem_addr,
  input  logic [rv_pkg::XLEN-1:0] imem_data,
  output logic                    io_valid,
  output logic [rv_pkg::XLEN-1:0] io_data,
  output logic                    halted
);

  import rv_pkg::*;

  phase_e          phase;
  insn_u           insn;
  logic [XLEN-1:0] pc;
  logic [4:0]      rs1_sel;
  logic [4:0]      rs2_sel;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  dec_t            dec;
  exe_t            exe;
  wb_t             wb;

  fetch_stage u_fetch (
    .clk       (clk),
    .arst_n    (arst_n),
    .wb        (wb),
    .phase     (phase),
    .insn      (insn),
    .pc        (pc),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .halted    (halted)
  );

  decode_stage u_decode (
    .insn     (insn),
    .pc       (pc),
    .rs1_sel  (rs1_sel),
    .rs2_sel  (rs2_sel),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dec      (dec)
  );

  reg_file u_regs (
    .clk      (clk),
    .rs1_sel  (rs1_sel),
    .rs2_sel  (rs2_sel),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb),
    .phase    (phase)
  );

  execute_stage u_execute (
    .dec (dec),
    .exe (exe)
  );

  mem_stage u_mem (
    .clk      (clk),
    .arst_n   (arst_n),
    .phase    (phase),
    .exe      (exe),
    .wb       (wb),
    .io_valid (io_valid),
    .io_data  (io_data)
  );

endmodule

/* design/mem_stage.sv */
`timescale 1ns/1ns

module mem_stage (
  input  logic                    clk,
  input  logic                    arst_n,
  input  rv_pkg::phase_e          phase,
  input  rv_pkg::exe_t            exe,
  output rv_pkg::wb_t             wb,
  output logic                    io_valid,
  output logic [rv_pkg::XLEN-1:0] io_data
);

  import rv_pkg::*;

  logic [XLEN-1:0]    dmem [DMEM_WORDS];
  logic               is_io;
  logic [DMEM_AW-1:0] widx;
  logic [XLEN-1:0]    load_data;
  logic [XLEN-1:0]    wdata;
  logic               mem_slot;
  logic               wen_q;
  logic               halt_q;
  logic [4:0]         rd_q;
  logic [XLEN-1:0]    wdata_q;
  logic [XLEN-1:0]    next_pc_q;

  // bit 31 maps to the output port
  assign is_io     = exe.alu_res[XLEN-1];
  assign widx      = exe.alu_res[DMEM_AW+1:2];
  assign mem_slot  = (phase == PH_EXEC);
  assign load_data = (exe.ctrl.mem_read && !is_io) ? dmem[widx] : '0;

  always_comb begin
    case (exe.ctrl.wb_sel)
      WB_MEM:  wdata = load_data;
      WB_PC4:  wdata = exe.pc + 32'd4;
      default: wdata = exe.alu_res;
    endcase
  end

  always_ff @(posedge clk) begin
    if (mem_slot && exe.ctrl.mem_write && !is_io) begin
      dmem[widx] <= exe.store_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wen_q    <= 1'b0;
      halt_q   <= 1'b0;
      io_valid <= 1'b0;
    end else begin
      io_valid <= mem_slot && exe.ctrl.mem_write && is_io;
      if (mem_slot) begin
        wen_q  <= exe.ctrl.rf_wen;
        halt_q <= exe.ctrl.halt;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_slot) begin
      rd_q      <= exe.ctrl.rd;
      wdata_q   <= wdata;
      next_pc_q <= exe.next_pc;
      if (exe.ctrl.mem_write && is_io) begin
        io_data <= exe.store_data;
      end
    end
  end

  assign wb = '{wen: wen_q, rd: rd_q, wdata: wdata_q, next_pc: next_pc_q, halt: halt_q};

endmodule

/* design/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
  input  rv_pkg::dec_t dec,
  output rv_pkg::exe_t exe
);

  import rv_pkg::*;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [4:0]      shamt;
  logic [XLEN-1:0] alu_res;
  logic            taken;
  logic [XLEN-1:0] next_pc;

  assign op_a  = dec.ctrl.op1_pc ? dec.pc : dec.rs1_val;
  assign op_b  = dec.ctrl.op2_imm ? dec.imm : dec.rs2_val;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.ctrl.alu_op)
      ALU_ADD:    alu_res = op_a + op_b;
      ALU_SUB:    alu_res = op_a - op_b;
      ALU_SLL:    alu_res = op_a << shamt;
      ALU_SLT:    alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_res = {31'd0, op_a < op_b};
      ALU_XOR:    alu_res = op_a ^ op_b;
      ALU_SRL:    alu_res = op_a >> shamt;
      ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> shamt);
      ALU_OR:     alu_res = op_a | op_b;
      ALU_AND:    alu_res = op_a & op_b;
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = '0;
    endcase
  end

  // compare always on the register values
  always_comb begin
    case (dec.ctrl.br_cond)
      BR_EQ:   taken = (dec.rs1_val == dec.rs2_val);
      BR_NE:   taken = (dec.rs1_val != dec.rs2_val);
      BR_LT:   taken = ($signed(dec.rs1_val) < $signed(dec.rs2_val));
      BR_GE:   taken = ($signed(dec.rs1_val) >= $signed(dec.rs2_val));
      BR_LTU:  taken = (dec.rs1_val < dec.rs2_val);
      BR_GEU:  taken = (dec.rs1_val >= dec.rs2_val);
      BR_JUMP: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (dec.ctrl.jalr) begin
      next_pc = {alu_res[XLEN-1:1], 1'b0};
    end else if (taken) begin
      next_pc = dec.pc + dec.imm;
    end else begin
      next_pc = dec.pc + 32'd4;
    end
  end

  assign exe = '{ctrl: dec.ctrl, pc: dec.pc, alu_res: alu_res,
                 store_data: dec.rs2_val, next_pc: next_pc};

endmodule

/* design/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
  input  logic                    clk,
  input  logic [4:0]              rs1_sel,
  input  logic [4:0]              rs2_sel,
  output logic [rv_pkg::XLEN-1:0] rs1_data,
  output logic [rv_pkg::XLEN-1:0] rs2_data,
  input  rv_pkg::wb_t             wb,
  input  rv_pkg::phase_e          phase
);

  import rv_pkg::*;

  logic [XLEN-1:0] regs [32];

  // single write slot per instruction
  always_ff @(posedge clk) begin
    if (phase == PH_WB && wb.wen && wb.rd != 5'd0) begin
      regs[wb.rd] <= wb.wdata;
    end
  end

  // x0 never read from the array
  assign rs1_data = (rs1_sel == 5'd0) ? '0 : regs[rs1_sel];
  assign rs2_data = (rs2_sel == 5'd0) ? '0 : regs[rs2_sel];

endmodule

/* design/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
  input  rv_pkg::insn_u           insn,
  input  logic [rv_pkg::XLEN-1:0] pc,
  output logic [4:0]              rs1_sel,
  output logic [4:0]              rs2_sel,
  input  logic [rv_pkg::XLEN-1:0] rs1_data,
  input  logic [rv_pkg::XLEN-1:0] rs2_data,
  output rv_pkg::dec_t            dec
);

  import rv_pkg::*;

  ctrl_t           ctrl;
  logic [XLEN-1:0] imm;
  alu_op_e         arith_op;

  assign rs1_sel = insn.r.rs1;
  assign rs2_sel = insn.r.rs2;

  // funct3 to alu op, bit 30 picks sub and sra
  always_comb begin
    case (insn.r.funct3)
      3'b000:  arith_op = (insn.r.opcode == OPC_OP && insn.r.funct7[5]) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = insn.r.funct7[5] ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    ctrl.rd        = insn.r.rd;
    ctrl.rf_wen    = 1'b0;
    ctrl.alu_op    = ALU_ADD;
    ctrl.op1_pc    = 1'b0;
    ctrl.op2_imm   = 1'b0;
    ctrl.br_cond   = BR_NONE;
    ctrl.mem_read  = 1'b0;
    ctrl.mem_write = 1'b0;
    ctrl.wb_sel    = WB_ALU;
    ctrl.jalr      = 1'b0;
    ctrl.halt      = 1'b0;
    imm            = '0;
    case (insn.r.opcode)
      OPC_LUI, OPC_AUIPC: begin
        imm          = {insn.u.imm, 12'h000};
        ctrl.rf_wen  = 1'b1;
        ctrl.op2_imm = 1'b1;
        ctrl.op1_pc  = (insn.u.opcode == OPC_AUIPC);
        ctrl.alu_op  = (insn.u.opcode == OPC_LUI) ? ALU_PASS_B : ALU_ADD;
      end
      OPC_JAL: begin
        imm          = {{11{insn.j.imm20}}, insn.j.imm20, insn.j.imm19_12,
                        insn.j.imm11, insn.j.imm10_1, 1'b0};
        ctrl.rf_wen  = 1'b1;
        ctrl.br_cond = BR_JUMP;
        ctrl.wb_sel  = WB_PC4;
      end
      OPC_JALR: begin
        imm          = {{20{insn.i.imm[11]}}, insn.i.imm};
        ctrl.rf_wen  = 1'b1;
        ctrl.op2_imm = 1'b1;
        ctrl.jalr    = 1'b1;
        ctrl.br_cond = BR_JUMP;
        ctrl.wb_sel  = WB_PC4;
      end
      OPC_BRANCH: begin
        imm = {{19{insn.b.imm12}}, insn.b.imm12, insn.b.imm11,
               insn.b.imm10_5, insn.b.imm4_1, 1'b0};
        case (insn.b.funct3)
          3'b000:  ctrl.br_cond = BR_EQ;
          3'b001:  ctrl.br_cond = BR_NE;
          3'b100:  ctrl.br_cond = BR_LT;
          3'b101:  ctrl.br_cond = BR_GE;
          3'b110:  ctrl.br_cond = BR_LTU;
          3'b111:  ctrl.br_cond = BR_GEU;
          default: ctrl.br_cond = BR_NONE;
        endcase
      end
      OPC_LOAD: begin
        imm           = {{20{insn.i.imm[11]}}, insn.i.imm};
        ctrl.rf_wen   = 1'b1;
        ctrl.op2_imm  = 1'b1;
        ctrl.mem_read = 1'b1;
        ctrl.wb_sel   = WB_MEM;
      end
      OPC_STORE: begin
        imm            = {{20{insn.s.imm_hi[6]}}, insn.s.imm_hi, insn.s.imm_lo};
        ctrl.op2_imm   = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      OPC_OP_IMM: begin
        imm          = {{20{insn.i.imm[11]}}, insn.i.imm};
        ctrl.rf_wen  = 1'b1;
        ctrl.op2_imm = 1'b1;
        ctrl.alu_op  = arith_op;
      end
      OPC_OP: begin
        ctrl.rf_wen = 1'b1;
        ctrl.alu_op = arith_op;
      end
      OPC_SYSTEM: begin
        // only ebreak, everything else falls through as a no-op
        ctrl.halt = (insn.i.imm == 12'h001) && (insn.i.funct3 == 3'b000) &&
                    (insn.i.rs1 == 5'd0) && (insn.i.rd == 5'd0);
      end
      default: ;
    endcase
  end

  assign dec = '{ctrl: ctrl, pc: pc, rs1_val: rs1_data, rs2_val: rs2_data, imm: imm};

endmodule

/* design/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage (
  input  logic                    clk,
  input  logic                    arst_n,
  input  rv_pkg::wb_t             wb,
  output rv_pkg::phase_e          phase,
  output rv_pkg::insn_u           insn,
  output logic [rv_pkg::XLEN-1:0] pc,
  output logic [rv_pkg::XLEN-1:0] imem_addr,
  input  logic [rv_pkg::XLEN-1:0] imem_data,
  output logic                    halted
);

  import rv_pkg::*;

  // three-phase sequencer, frozen in PH_FETCH once halted
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase  <= PH_FETCH;
      pc     <= RESET_PC;
      halted <= 1'b0;
    end else if (!halted) begin
      case (phase)
        PH_FETCH: phase <= PH_EXEC;
        PH_EXEC:  phase <= PH_WB;
        PH_WB: begin
          phase <= PH_FETCH;
          if (wb.halt) begin
            halted <= 1'b1;
          end else begin
            pc <= wb.next_pc;
          end
        end
        default: phase <= PH_FETCH;
      endcase
    end
  end

  // instruction register
  always_ff @(posedge clk) begin
    if (phase == PH_FETCH && !halted) begin
      insn <= imem_data;
    end
  end

  assign imem_addr = pc;

endmodule

/* design/rv_pkg.sv */
package rv_pkg;

  localparam int XLEN       = 32;
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
  localparam int DMEM_WORDS = 256;
  localparam int DMEM_AW    = $clog2(DMEM_WORDS);

  typedef enum logic [1:0] {
    PH_FETCH = 2'd0,
    PH_EXEC  = 2'd1,
    PH_WB    = 2'd2
  } phase_e;

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JUMP
  } br_cond_e;

  typedef enum logic [1:0] {
    WB_ALU, WB_MEM, WB_PC4
  } wb_sel_e;

  // instruction format views, msb first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } insn_r_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } insn_i_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } insn_s_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } insn_b_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } insn_u_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } insn_j_t;

  typedef union packed {
    insn_r_t r;
    insn_i_t i;
    insn_s_t s;
    insn_b_t b;
    insn_u_t u;
    insn_j_t j;
  } insn_u;

  typedef struct packed {
    logic [4:0] rd;
    logic       rf_wen;
    alu_op_e    alu_op;
    logic       op1_pc;
    logic       op2_imm;
    br_cond_e   br_cond;
    logic       mem_read;
    logic       mem_write;
    wb_sel_e    wb_sel;
    logic       jalr;
    logic       halt;
  } ctrl_t;

  typedef struct packed {
    ctrl_t           ctrl;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] imm;
  } dec_t;

  typedef struct packed {
    ctrl_t           ctrl;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] store_data;
    logic [XLEN-1:0] next_pc;
  } exe_t;

  typedef struct packed {
    logic            wen;
    logic [4:0]      rd;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] next_pc;
    logic            halt;
  } wb_t;

endpackage
